// ==== Bender.yml ====
package:
  name: agc

sources:
  - files:
      - hw/agc_pkg.sv
      - hw/power_avg_meter.sv
      - hw/gain_loop.sv
      - hw/lane_scaler.sv
      - hw/agc_top.sv
  - target: test
    files:
      - tb/agc_checker.sv
      - tb/agc_tb.sv

// ==== agc.f ====
hw/agc_pkg.sv
hw/power_avg_meter.sv
hw/gain_loop.sv
hw/lane_scaler.sv
hw/agc_top.sv
tb/agc_checker.sv
tb/agc_tb.sv

// ==== hw/agc_pkg.sv ====
// widths, fixed-point formats and typedefs for the gain control path
// loop constants and the gain after reset
`default_nettype none

package agc_pkg;

    // sample stream
    localparam int DIN_WIDTH = 8;
    localparam int DIN_POINT = 7;
    localparam int PARALLEL = 4;
    localparam int LANE_LOG2 = $clog2(PARALLEL);

    // power, gain and coefficient formats
    localparam int POW_WIDTH = 2 * DIN_WIDTH;
    localparam int POW_POINT = 2 * DIN_POINT;
    localparam int GAIN_WIDTH = 16;
    localparam int GAIN_POINT = 8;
    localparam int COEF_WIDTH = 16;
    localparam int COEF_POINT = 8;
    localparam int DOUT_WIDTH = DIN_WIDTH + GAIN_WIDTH;

    // meter and loop internals
    localparam int LSUM_WIDTH = POW_WIDTH + LANE_LOG2;
    localparam int AVG_LEN_LOG2 = 4;
    localparam int AVG_LEN = 1 << AVG_LEN_LOG2;
    localparam int WSUM_WIDTH = POW_WIDTH + AVG_LEN_LOG2;
    localparam int PG_WIDTH = POW_WIDTH + GAIN_WIDTH + 1;
    localparam int DIFF_WIDTH = POW_WIDTH + 1;
    localparam int ERR_WIDTH = DIFF_WIDTH + COEF_WIDTH;
    // brings the error product back to gain format
    localparam int ERR_SHIFT = POW_POINT + COEF_POINT - GAIN_POINT;
    localparam int UPDATE_CYCLES = 64;
    localparam int CNT_WIDTH = $clog2(UPDATE_CYCLES);

    typedef logic signed [DIN_WIDTH-1:0]           sample_t;
    typedef logic [PARALLEL*DIN_WIDTH-1:0]         block_t;
    typedef logic [POW_WIDTH-1:0]                  pow_t;
    typedef logic signed [GAIN_WIDTH-1:0]          gain_t;
    typedef logic signed [COEF_WIDTH-1:0]          coef_t;
    typedef logic [PARALLEL*DOUT_WIDTH-1:0]        dout_block_t;

    // clamp bounds are exclusive
    localparam gain_t GAIN_HIGH = gain_t'(8 << GAIN_POINT);
    localparam gain_t GAIN_LOW = gain_t'(0);
    localparam gain_t GAIN_INIT = gain_t'(1 << GAIN_POINT);
    // 0.25, the offset of the square-root line
    localparam gain_t SCALE_OFFSET = gain_t'(1 << (GAIN_POINT - 2));

endpackage

`default_nettype wire

// ==== hw/agc_top.sv ====
// automatic gain control top level
// power meter and lane scaler side by side on din, gain loop between them
`timescale 1ns/100ps
`default_nettype none

module agc_top import agc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  block_t      din,
    input  logic        din_valid,
    input  pow_t        ref_pow,
    input  coef_t       error_coef,
    output gain_t       gain,
    output logic        gain_valid,
    output dout_block_t dout,
    output logic        dout_valid
);

    pow_t  avg_pow;
    logic  avg_valid;
    gain_t scale;

    power_avg_meter meter_i (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_valid (din_valid),
        .avg_pow   (avg_pow),
        .avg_valid (avg_valid)
    );

    gain_loop loop_i (
        .clk        (clk),
        .rst        (rst),
        .avg_pow    (avg_pow),
        .avg_valid  (avg_valid),
        .ref_pow    (ref_pow),
        .error_coef (error_coef),
        .gain       (gain),
        .gain_valid (gain_valid),
        .scale      (scale)
    );

    // scale changes one cycle after each gain pulse
    lane_scaler scaler_i (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .scale      (scale),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

// ==== hw/gain_loop.sv ====
// gain feedback loop: power times gain against the reference, scaled error,
// periodic clamped gain update and the derived lane scale
`timescale 1ns/100ps
`default_nettype none

module gain_loop import agc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  pow_t  avg_pow,
    input  logic  avg_valid,
    input  pow_t  ref_pow,
    input  coef_t error_coef,
    output gain_t gain,
    output logic  gain_valid,
    output gain_t scale
);

    logic signed [PG_WIDTH-1:0]   pg_prod;
    logic                         pg_valid;
    pow_t                         pg_red;
    logic signed [DIFF_WIDTH-1:0] ref_diff;
    logic                         diff_valid;
    logic signed [ERR_WIDTH-1:0]  err_prod;
    logic                         err_valid;
    logic signed [ERR_WIDTH-1:0]  err_shifted;
    logic [ERR_WIDTH-GAIN_WIDTH:0] err_top;
    gain_t                        err_sat;
    gain_t                        err_term;
    logic [CNT_WIDTH-1:0]         cnt;
    logic signed [GAIN_WIDTH:0]   gain_cand;
    logic                         cand_ok;

    // average power times current gain
    always_ff @(posedge clk) begin
        if (avg_valid) begin
            pg_prod <= $signed({1'b0, avg_pow}) * gain;
        end
    end

    // drop GAIN_POINT bits, pin to full scale if the top overflows
    always_comb begin
        if (pg_prod[PG_WIDTH-1:GAIN_POINT+POW_WIDTH] != '0) begin
            pg_red = '1;
        end else begin
            pg_red = pg_prod[GAIN_POINT +: POW_WIDTH];
        end
    end

    // positive when the output is below the reference
    always_ff @(posedge clk) begin
        if (pg_valid) begin
            ref_diff <= $signed({1'b0, ref_pow}) - $signed({1'b0, pg_red});
        end
    end

    always_ff @(posedge clk) begin
        if (diff_valid) begin
            err_prod <= ref_diff * error_coef;
        end
    end

    // saturating cast to gain format
    always_comb begin
        err_shifted = err_prod >>> ERR_SHIFT;
        err_top = err_shifted[ERR_WIDTH-1:GAIN_WIDTH-1];
        if ((&err_top) || !(|err_top)) begin
            err_sat = err_shifted[GAIN_WIDTH-1:0];
        end else if (err_shifted[ERR_WIDTH-1]) begin
            err_sat = {1'b1, {(GAIN_WIDTH-1){1'b0}}};
        end else begin
            err_sat = {1'b0, {(GAIN_WIDTH-1){1'b1}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pg_valid <= 1'b0;
            diff_valid <= 1'b0;
            err_valid <= 1'b0;
            err_term <= '0;
        end else begin
            pg_valid <= avg_valid;
            diff_valid <= pg_valid;
            err_valid <= diff_valid;
            // latest error term, held between updates
            if (err_valid) begin
                err_term <= err_sat;
            end
        end
    end

    // one extra bit so the bound check sees no wrap
    assign gain_cand = gain + err_term;
    assign cand_ok = (gain_cand > GAIN_LOW) && (gain_cand < GAIN_HIGH);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            gain <= GAIN_INIT;
            gain_valid <= 1'b0;
            scale <= (GAIN_INIT >>> 1) + SCALE_OFFSET;
        end else begin
            gain_valid <= 1'b0;
            if (cnt == CNT_WIDTH'(UPDATE_CYCLES - 1)) begin
                cnt <= '0;
                gain_valid <= 1'b1;
                // rejected candidate keeps the old gain
                if (cand_ok) begin
                    gain <= gain_cand[GAIN_WIDTH-1:0];
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
            // sqrt estimate, gain/2 + 0.25
            if (gain_valid) begin
                scale <= (gain >>> 1) + SCALE_OFFSET;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/lane_scaler.sv ====
// multiplies every lane of a sample block by the current scale
// products in stage one, output register in stage two
`timescale 1ns/100ps
`default_nettype none

module lane_scaler import agc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  block_t      din,
    input  logic        din_valid,
    input  gain_t       scale,
    output dout_block_t dout,
    output logic        dout_valid
);

    sample_t                      lane [PARALLEL];
    logic signed [DOUT_WIDTH-1:0] prod [PARALLEL];
    logic [1:0]                   vld_sr;

    always_comb begin
        for (int i = 0; i < PARALLEL; i++) begin
            lane[i] = din[i*DIN_WIDTH +: DIN_WIDTH];
        end
    end

    // full-width signed product per lane
    always_ff @(posedge clk) begin
        if (din_valid) begin
            for (int i = 0; i < PARALLEL; i++) begin
                prod[i] <= lane[i] * scale;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vld_sr[0]) begin
            for (int i = 0; i < PARALLEL; i++) begin
                dout[i*DOUT_WIDTH +: DOUT_WIDTH] <= prod[i];
            end
        end
    end

    // valid follows the data, two blocks may be in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[0], din_valid};
        end
    end

    assign dout_valid = vld_sr[1];

endmodule

`default_nettype wire

// ==== hw/power_avg_meter.sv ====
// block power meter: per-lane squares, lane sum and a sliding-window
// average over the last AVG_LEN blocks
`timescale 1ns/100ps
`default_nettype none

module power_avg_meter import agc_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  block_t din,
    input  logic   din_valid,
    output pow_t   avg_pow,
    output logic   avg_valid
);

    sample_t               lane [PARALLEL];
    pow_t                  sq [PARALLEL];
    logic                  sq_valid;
    logic [LSUM_WIDTH-1:0] lane_sum;
    pow_t                  blk_pow;
    logic                  blk_valid;
    pow_t                  window [AVG_LEN];
    logic [WSUM_WIDTH-1:0] win_sum;

    always_comb begin
        for (int i = 0; i < PARALLEL; i++) begin
            lane[i] = din[i*DIN_WIDTH +: DIN_WIDTH];
        end
    end

    // stage 1, square of each lane is never negative
    always_ff @(posedge clk) begin
        if (din_valid) begin
            for (int i = 0; i < PARALLEL; i++) begin
                sq[i] <= lane[i] * lane[i];
            end
        end
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < PARALLEL; i++) begin
            lane_sum = lane_sum + LSUM_WIDTH'(sq[i]);
        end
    end

    // stage 2, top bits of the lane sum
    always_ff @(posedge clk) begin
        if (sq_valid) begin
            blk_pow <= lane_sum[LSUM_WIDTH-1 -: POW_WIDTH];
        end
    end

    // stage 3, newest power in, oldest power out
    always_ff @(posedge clk) begin
        if (rst) begin
            win_sum <= '0;
            for (int i = 0; i < AVG_LEN; i++) begin
                window[i] <= '0;
            end
        end else if (blk_valid) begin
            win_sum <= win_sum + WSUM_WIDTH'(blk_pow) - WSUM_WIDTH'(window[AVG_LEN-1]);
            window[0] <= blk_pow;
            for (int i = 1; i < AVG_LEN; i++) begin
                window[i] <= window[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sq_valid <= 1'b0;
            blk_valid <= 1'b0;
            avg_valid <= 1'b0;
        end else begin
            sq_valid <= din_valid;
            blk_valid <= sq_valid;
            avg_valid <= blk_valid;
        end
    end

    // divide by window length, truncating
    assign avg_pow = pow_t'(win_sum >> AVG_LEN_LOG2);

endmodule

`default_nettype wire

// ==== tb/agc_checker.sv ====
// concurrent assertions on the gain control top level
// attached to agc_top by bind
`timescale 1ns/100ps
`default_nettype none

module agc_checker import agc_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  din_valid,
    input logic  dout_valid,
    input gain_t gain,
    input logic  gain_valid,
    input gain_t scale
);

    int unsigned failures = 0;

    // registers still hold their reset values right after release
    reset_values: assert property (@(posedge clk)
        $fell(rst) |-> (gain == GAIN_INIT) && !gain_valid && !dout_valid)
        else begin
            failures++;
            $error("gain or a valid strobe is wrong right after reset");
        end

    valid_delay: assert property (@(posedge clk) disable iff (rst)
        dout_valid == $past(din_valid, 2))
        else begin
            failures++;
            $error("dout_valid is not din_valid delayed by two cycles");
        end

    pulse_spacing: assert property (@(posedge clk) disable iff (rst)
        gain_valid |=> !gain_valid [*UPDATE_CYCLES-1] ##1 gain_valid)
        else begin
            failures++;
            $error("gain_valid pulses are not UPDATE_CYCLES apart");
        end

    gain_hold: assert property (@(posedge clk) disable iff (rst)
        $changed(gain) |-> gain_valid)
        else begin
            failures++;
            $error("gain changed outside a gain_valid pulse");
        end

    // exclusive bounds, or the value after reset
    gain_range: assert property (@(posedge clk) disable iff (rst)
        ((gain > GAIN_LOW) && (gain < GAIN_HIGH)) || (gain == GAIN_INIT))
        else begin
            failures++;
            $error("gain left the clamp range");
        end

    scale_follow: assert property (@(posedge clk) disable iff (rst)
        gain_valid |=> scale == $past(gain) / 2 + SCALE_OFFSET)
        else begin
            failures++;
            $error("scale is not half the gain plus one quarter");
        end

endmodule

bind agc_top agc_checker checker_i (
    .clk        (clk),
    .rst        (rst),
    .din_valid  (din_valid),
    .dout_valid (dout_valid),
    .gain       (gain),
    .gain_valid (gain_valid),
    .scale      (scale)
);

`default_nettype wire

// ==== tb/agc_tb.sv ====
// testbench for the gain control top level
// LFSR stimulus in a quiet and a loud phase, dout model and gain direction checks
`timescale 1ns/100ps
`default_nettype none

module agc_tb import agc_pkg::*;;

    logic        clk;
    logic        rst;
    block_t      din;
    logic        din_valid;
    pow_t        ref_pow;
    coef_t       error_coef;
    gain_t       gain;
    logic        gain_valid;
    dout_block_t dout;
    logic        dout_valid;

    logic [31:0] lfsr;
    int          amp_shift;
    int          errors;

    // dout model, two blocks in flight
    dout_block_t exp_d1;
    dout_block_t exp_d2;
    logic        vld_d1;
    logic        vld_d2;
    gain_t       model_scale;
    gain_t       next_scale;
    logic        scale_due;

    agc_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .ref_pow    (ref_pow),
        .error_coef (error_coef),
        .gain       (gain),
        .gain_valid (gain_valid),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // signed product of every lane with the scale
    function automatic dout_block_t expect_block(input block_t blk, input gain_t sc);
        dout_block_t                  r;
        sample_t                      s;
        logic signed [DOUT_WIDTH-1:0] p;
        int                           i;
        for (i = 0; i < PARALLEL; i++) begin
            s = blk[i*DIN_WIDTH +: DIN_WIDTH];
            p = s * sc;
            r[i*DOUT_WIDTH +: DOUT_WIDTH] = p;
        end
        return r;
    endfunction

    task automatic drive_cycle();
        logic [DIN_WIDTH-1:0] bits;
        int                   i;
        @(posedge clk);
        #1;
        // roughly one block in four is a gap
        din_valid = (take_bits(2) != 0);
        for (i = 0; i < PARALLEL; i++) begin
            bits = DIN_WIDTH'(take_bits(DIN_WIDTH));
            din[i*DIN_WIDTH +: DIN_WIDTH] = $signed(bits) >>> amp_shift;
        end
    endtask

    task automatic wait_gain_pulse(output gain_t g);
        int cycles;
        g = gain;
        for (cycles = 0; cycles < 2 * UPDATE_CYCLES; cycles++) begin
            drive_cycle();
            if (gain_valid) begin
                g = gain;
                return;
            end
        end
        errors++;
        $display("timeout at %0t, no gain_valid pulse seen", $time);
    endtask

    task automatic run_phase(input int shift, input pow_t target, input logic rising);
        gain_t first;
        gain_t prev;
        gain_t g;
        logic  ok;
        int    n;
        amp_shift = shift;
        ref_pow = target;
        // first pulse may still carry the error term of the previous phase
        wait_gain_pulse(first);
        prev = first;
        g = first;
        for (n = 0; n < 8; n++) begin
            wait_gain_pulse(g);
            ok = rising ? (g >= prev) : (g <= prev);
            assert (ok) else begin
                errors++;
                $display("gain moved the wrong way at %0t, from %h to %h", $time, prev, g);
            end
            prev = g;
        end
        ok = rising ? (g > first) : (g < first);
        assert (ok) else begin
            errors++;
            $display("gain did not settle away from %h by %0t, now %h", first, $time, g);
        end
    endtask

    // outputs are checked between edges, where they are stable
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            vld_d1 = 1'b0;
            vld_d2 = 1'b0;
            scale_due = 1'b0;
            model_scale = GAIN_INIT / 2 + SCALE_OFFSET;
        end else begin
            if (scale_due) begin
                model_scale = next_scale;
                scale_due = 1'b0;
            end
            if (gain_valid) begin
                next_scale = gain / 2 + SCALE_OFFSET;
                scale_due = 1'b1;
            end
            assert (dout_valid == vld_d2) else begin
                errors++;
                $display("MISMATCH %0t dout_valid expected %b actual %b",
                         $time, vld_d2, dout_valid);
            end
            if (vld_d2) begin
                assert (dout == exp_d2) else begin
                    errors++;
                    $display("MISMATCH %0t dout expected %h actual %h", $time, exp_d2, dout);
                end
            end
            exp_d2 = exp_d1;
            vld_d2 = vld_d1;
            exp_d1 = expect_block(din, model_scale);
            vld_d1 = din_valid;
        end
    end

    initial begin
        rst = 1'b1;
        din = '0;
        din_valid = 1'b0;
        ref_pow = '0;
        error_coef = '0;
        lfsr = 32'h42c0_6936;
        amp_shift = 0;
        errors = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // 1.0 in coefficient format
        // quiet phase then runs into the upper gain bound
        error_coef = coef_t'(256);
        // quiet input against 1.0 reference power
        run_phase(4, 16'h4000, 1'b1);
        run_phase(0, 16'h0100, 1'b0);
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        $display("errors: %0d testbench, %0d assertion", errors, dut_i.checker_i.failures);
        if (errors == 0 && dut_i.checker_i.failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
